//--- logic/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    // R-type field layout
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    // I-type field layout
    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    // ALU_NONE retires without a register write
    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

endpackage

//--- logic/core_pkg.sv
package core_pkg;

    // One slot of the fetch-to-execute buffer
    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::inst_t inst;
    } fetch_entry_t;

    localparam int QUEUE_DEPTH = 4;

    // First fetch address after reset
    localparam isa_pkg::word_t RESET_PC = 32'h0000_0000;

endpackage

//--- logic/queue_if.sv
`timescale 1ns/1ps

interface queue_if;

    logic                   push;
    core_pkg::fetch_entry_t push_data;
    logic                   full;
    logic                   pop;
    core_pkg::fetch_entry_t pop_data;
    logic                   empty;

    modport producer (output push, output push_data, input full);

    modport buffer (
        input  push,
        input  push_data,
        input  pop,
        output full,
        output empty,
        output pop_data
    );

    modport consumer (input empty, input pop_data, output pop);

endinterface

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rst_n_i,
    input  isa_pkg::reg_addr_t raddr_a_i,
    input  isa_pkg::reg_addr_t raddr_b_i,
    output isa_pkg::word_t     rdata_a_o,
    output isa_pkg::word_t     rdata_b_o,
    input  logic               we_i,
    input  isa_pkg::reg_addr_t waddr_i,
    input  isa_pkg::word_t     wdata_i
);

    // r0 has no storage
    isa_pkg::word_t regs [31:1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rdata_a_o = '0;
        if (raddr_a_i != '0) begin
            rdata_a_o = regs[raddr_a_i];
        end
    end

    always_comb begin
        rdata_b_o = '0;
        if (raddr_b_i != '0) begin
            rdata_b_o = regs[raddr_b_i];
        end
    end

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic           clk,
    input  logic           rst_n_i,
    output logic           wb_cyc_o,
    output logic           wb_stb_o,
    output isa_pkg::word_t wb_adr_o,
    input  isa_pkg::word_t wb_dat_i,
    input  logic           wb_ack_i,
    queue_if.producer      q
);

    typedef enum logic {
        S_IDLE,
        S_WAIT_ACK
    } state_e;

    state_e         state;
    isa_pkg::word_t pc;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= S_IDLE;
            pc    <= core_pkg::RESET_PC;
        end else begin
            case (state)
                S_IDLE: begin
                    // Only start when the entry is sure to fit
                    if (!q.full) begin
                        state <= S_WAIT_ACK;
                    end
                end
                S_WAIT_ACK: begin
                    if (wb_ack_i) begin
                        state <= S_IDLE;
                        pc    <= pc + 32'd4;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Bus request held for the whole wait
    assign wb_cyc_o = (state == S_WAIT_ACK);
    assign wb_stb_o = (state == S_WAIT_ACK);
    assign wb_adr_o = pc;

    // Push on the ack edge
    assign q.push           = (state == S_WAIT_ACK) && wb_ack_i;
    assign q.push_data.pc   = pc;
    assign q.push_data.inst = wb_dat_i;

endmodule

//--- logic/inst_queue.sv
`timescale 1ns/1ps

module inst_queue #(
    parameter int DEPTH = 4
) (
    input  logic    clk,
    input  logic    rst_n_i,
    queue_if.buffer q_in,
    queue_if.buffer q_out
);

    core_pkg::fetch_entry_t mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [$clog2(DEPTH)-1:0] next_ptr(
        input logic [$clog2(DEPTH)-1:0] ptr
    );
        if (ptr == DEPTH - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_push = q_in.push && !q_in.full;
    assign do_pop  = q_out.pop && !q_out.empty;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= q_in.push_data;
        end
    end

    assign q_in.full      = (count == DEPTH);
    assign q_out.empty    = (count == 0);
    assign q_out.pop_data = mem[rd_ptr];

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               stall_i,
    queue_if.consumer          q,
    output logic               wb_we_o,
    output isa_pkg::word_t     wb_pc_o,
    output isa_pkg::reg_addr_t wb_waddr_o,
    output isa_pkg::word_t     wb_wdata_o
);

    isa_pkg::r_fmt_t    r_fmt;
    isa_pkg::i_fmt_t    i_fmt;
    isa_pkg::alu_op_e   alu_op;
    isa_pkg::reg_addr_t dest;
    isa_pkg::word_t     op_a;
    isa_pkg::word_t     op_b;
    isa_pkg::word_t     rs_data;
    isa_pkg::word_t     rt_data;
    isa_pkg::word_t     result;
    logic               do_write;

    assign q.pop = !q.empty && !stall_i;

    assign r_fmt = isa_pkg::r_fmt_t'(q.pop_data.inst);
    assign i_fmt = isa_pkg::i_fmt_t'(q.pop_data.inst);

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (r_fmt.rs),
        .raddr_b_i (r_fmt.rt),
        .rdata_a_o (rs_data),
        .rdata_b_o (rt_data),
        .we_i      (do_write),
        .waddr_i   (dest),
        .wdata_i   (result)
    );

    // Decode; I-type writes rt and takes an immediate as operand b
    always_comb begin
        alu_op = isa_pkg::ALU_NONE;
        dest   = r_fmt.rd;
        op_a   = rs_data;
        op_b   = rt_data;
        case (r_fmt.opcode)
            isa_pkg::OP_SPECIAL: begin
                case (r_fmt.funct)
                    isa_pkg::FN_ADDU: alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:   alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_XOR:  alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::FN_NOR:  alu_op = isa_pkg::ALU_NOR;
                    isa_pkg::FN_SLT:  alu_op = isa_pkg::ALU_SLT;
                    default:          alu_op = isa_pkg::ALU_NONE;
                endcase
            end
            isa_pkg::OP_ADDIU: begin
                alu_op = isa_pkg::ALU_ADD;
                dest   = i_fmt.rt;
                op_b   = {{16{i_fmt.imm[15]}}, i_fmt.imm};
            end
            isa_pkg::OP_ANDI: begin
                alu_op = isa_pkg::ALU_AND;
                dest   = i_fmt.rt;
                op_b   = {16'h0000, i_fmt.imm};
            end
            isa_pkg::OP_ORI: begin
                alu_op = isa_pkg::ALU_OR;
                dest   = i_fmt.rt;
                op_b   = {16'h0000, i_fmt.imm};
            end
            isa_pkg::OP_XORI: begin
                alu_op = isa_pkg::ALU_XOR;
                dest   = i_fmt.rt;
                op_b   = {16'h0000, i_fmt.imm};
            end
            isa_pkg::OP_LUI: begin
                alu_op = isa_pkg::ALU_LUI;
                dest   = i_fmt.rt;
                op_b   = {i_fmt.imm, 16'h0000};
            end
            default: alu_op = isa_pkg::ALU_NONE;
        endcase
    end

    always_comb begin
        case (alu_op)
            isa_pkg::ALU_ADD: result = op_a + op_b;
            isa_pkg::ALU_SUB: result = op_a - op_b;
            isa_pkg::ALU_AND: result = op_a & op_b;
            isa_pkg::ALU_OR:  result = op_a | op_b;
            isa_pkg::ALU_XOR: result = op_a ^ op_b;
            isa_pkg::ALU_NOR: result = ~(op_a | op_b);
            isa_pkg::ALU_SLT: result = {31'd0, $signed(op_a) < $signed(op_b)};
            isa_pkg::ALU_LUI: result = op_b;
            default:          result = '0;
        endcase
    end

    // Write lands on the pop edge, so the next instruction sees it
    assign do_write = q.pop && (alu_op != isa_pkg::ALU_NONE) && (dest != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= do_write;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            wb_pc_o    <= q.pop_data.pc;
            wb_waddr_o <= dest;
            wb_wdata_o <= result;
        end
    end

endmodule

//--- logic/mips_core.sv
`timescale 1ns/1ps

module mips_core (
    input  logic               clk,
    input  logic               rst_n_i,

    // Instruction bus
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output isa_pkg::word_t     wb_adr_o,
    input  isa_pkg::word_t     wb_dat_i,
    input  logic               wb_ack_i,

    input  logic               stall_i,

    // Writeback trace
    output logic               wb_we_o,
    output isa_pkg::word_t     wb_pc_o,
    output isa_pkg::reg_addr_t wb_waddr_o,
    output isa_pkg::word_t     wb_wdata_o
);

    queue_if q_bus ();

    fetch_unit u_fetch (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i),
        .q        (q_bus)
    );

    // Same bus on both sides of the buffer
    inst_queue #(
        .DEPTH (core_pkg::QUEUE_DEPTH)
    ) u_queue (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .q_in    (q_bus),
        .q_out   (q_bus)
    );

    exec_unit u_exec (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall_i),
        .q          (q_bus),
        .wb_we_o    (wb_we_o),
        .wb_pc_o    (wb_pc_o),
        .wb_waddr_o (wb_waddr_o),
        .wb_wdata_o (wb_wdata_o)
    );

endmodule

//--- sim/core_properties.sv
`timescale 1ns/1ps

module core_properties (
    input logic           clk,
    input logic           rst_n_i,
    input logic           cyc_i,
    input logic           stb_i,
    input isa_pkg::word_t adr_i,
    input logic           ack_i
);

    int fail_count = 0;

    // Bus released in the cycle after ack
    a_cycle_ends: assert property (@(posedge clk) disable iff (!rst_n_i)
        (stb_i && ack_i) |=> (!cyc_i && !stb_i))
        else begin
            $error("Wishbone cycle still open in the cycle after ack");
            fail_count++;
        end

    // Request held until the slave answers
    a_request_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        (stb_i && !ack_i) |=> (stb_i && $stable(adr_i)))
        else begin
            $error("Wishbone request dropped or address changed before ack");
            fail_count++;
        end

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        stb_i |-> (adr_i[1:0] == 2'b00))
        else begin
            $error("Wishbone fetch address not word aligned");
            fail_count++;
        end

endmodule

bind fetch_unit core_properties u_props (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .cyc_i   (wb_cyc_o),
    .stb_i   (wb_stb_o),
    .adr_i   (wb_adr_o),
    .ack_i   (wb_ack_i)
);

//--- sim/mips_core_tb.sv
`timescale 1ns/1ps

module mips_core_tb;

    typedef struct {
        string              name;
        isa_pkg::inst_t     inst;
        isa_pkg::alu_op_e   op;
        isa_pkg::reg_addr_t rd;
        isa_pkg::reg_addr_t rs;
        isa_pkg::reg_addr_t rt;
        logic               use_imm;
        isa_pkg::word_t     imm;
    } row_t;

    typedef struct {
        string              name;
        isa_pkg::word_t     pc;
        isa_pkg::reg_addr_t rd;
        isa_pkg::word_t     data;
    } record_t;

    logic               clk = 1'b0;
    logic               rst_n_i = 1'b0;
    logic               stall_i = 1'b0;
    isa_pkg::word_t     wb_dat_i = '0;
    logic               wb_ack_i = 1'b0;
    logic               wb_cyc_o;
    logic               wb_stb_o;
    isa_pkg::word_t     wb_adr_o;
    logic               wb_we_o;
    isa_pkg::word_t     wb_pc_o;
    isa_pkg::reg_addr_t wb_waddr_o;
    isa_pkg::word_t     wb_wdata_o;

    row_t           prog[$];
    record_t        expected[$];
    int             mismatch_count = 0;
    int             timeout_count = 0;
    int             other_count = 0;
    int             rec_count = 0;
    int             ack_count = 0;
    int             wait_left = 0;
    logic [31:0]    rng = 32'ha107;
    isa_pkg::word_t next_adr = core_pkg::RESET_PC;

    mips_core DUT (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wb_cyc_o   (wb_cyc_o),
        .wb_stb_o   (wb_stb_o),
        .wb_adr_o   (wb_adr_o),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_i   (wb_ack_i),
        .stall_i    (stall_i),
        .wb_we_o    (wb_we_o),
        .wb_pc_o    (wb_pc_o),
        .wb_waddr_o (wb_waddr_o),
        .wb_wdata_o (wb_wdata_o)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_word(input string name, input isa_pkg::word_t exp,
                              input isa_pkg::word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_reg(input string name, input isa_pkg::reg_addr_t exp,
                             input isa_pkg::reg_addr_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic add_r(input string name, input logic [5:0] funct,
                         input isa_pkg::alu_op_e op, input isa_pkg::reg_addr_t rd,
                         input isa_pkg::reg_addr_t rs, input isa_pkg::reg_addr_t rt);
        row_t row;
        row.name    = name;
        row.inst    = {isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, funct};
        row.op      = op;
        row.rd      = rd;
        row.rs      = rs;
        row.rt      = rt;
        row.use_imm = 1'b0;
        row.imm     = '0;
        prog.push_back(row);
    endtask

    // I-type destination is rt
    task automatic add_i(input string name, input logic [5:0] opcode,
                         input isa_pkg::alu_op_e op, input isa_pkg::reg_addr_t rt,
                         input isa_pkg::reg_addr_t rs, input logic [15:0] imm16);
        row_t row;
        row.name    = name;
        row.inst    = {opcode, rs, rt, imm16};
        row.op      = op;
        row.rd      = rt;
        row.rs      = rs;
        row.rt      = '0;
        row.use_imm = 1'b1;
        if (opcode == isa_pkg::OP_ADDIU) begin
            row.imm = {{16{imm16[15]}}, imm16};
        end else if (opcode == isa_pkg::OP_LUI) begin
            row.imm = {imm16, 16'h0000};
        end else begin
            row.imm = {16'h0000, imm16};
        end
        prog.push_back(row);
    endtask

    task automatic build_program();
        add_i("ori_zext", isa_pkg::OP_ORI, isa_pkg::ALU_OR, 5'd1, 5'd0, 16'h1234);
        add_i("lui_upper", isa_pkg::OP_LUI, isa_pkg::ALU_LUI, 5'd2, 5'd0, 16'h8000);
        add_i("ori_high_imm", isa_pkg::OP_ORI, isa_pkg::ALU_OR, 5'd2, 5'd2, 16'hffff);
        add_i("addiu_sext", isa_pkg::OP_ADDIU, isa_pkg::ALU_ADD, 5'd3, 5'd0, 16'hfff0);
        add_i("andi_zext", isa_pkg::OP_ANDI, isa_pkg::ALU_AND, 5'd4, 5'd3, 16'h8ff0);
        add_i("xori_zext", isa_pkg::OP_XORI, isa_pkg::ALU_XOR, 5'd5, 5'd3, 16'hffff);
        add_r("addu", isa_pkg::FN_ADDU, isa_pkg::ALU_ADD, 5'd6, 5'd1, 5'd3);
        add_r("subu", isa_pkg::FN_SUBU, isa_pkg::ALU_SUB, 5'd7, 5'd1, 5'd3);
        add_r("and", isa_pkg::FN_AND, isa_pkg::ALU_AND, 5'd8, 5'd2, 5'd3);
        add_r("or", isa_pkg::FN_OR, isa_pkg::ALU_OR, 5'd9, 5'd1, 5'd4);
        add_r("xor", isa_pkg::FN_XOR, isa_pkg::ALU_XOR, 5'd10, 5'd2, 5'd5);
        add_r("nor", isa_pkg::FN_NOR, isa_pkg::ALU_NOR, 5'd11, 5'd1, 5'd3);
        add_r("slt_neg_pos", isa_pkg::FN_SLT, isa_pkg::ALU_SLT, 5'd12, 5'd3, 5'd1);
        add_r("slt_pos_neg", isa_pkg::FN_SLT, isa_pkg::ALU_SLT, 5'd13, 5'd1, 5'd3);
        add_r("slt_both_neg", isa_pkg::FN_SLT, isa_pkg::ALU_SLT, 5'd14, 5'd2, 5'd3);
        add_i("dep_chain_1", isa_pkg::OP_ADDIU, isa_pkg::ALU_ADD, 5'd15, 5'd15, 16'h0001);
        add_i("dep_chain_2", isa_pkg::OP_ADDIU, isa_pkg::ALU_ADD, 5'd15, 5'd15, 16'h0001);
        add_r("dep_chain_3", isa_pkg::FN_ADDU, isa_pkg::ALU_ADD, 5'd15, 5'd15, 5'd15);
        add_i("r0_write_i", isa_pkg::OP_ORI, isa_pkg::ALU_OR, 5'd0, 5'd0, 16'h5555);
        add_r("r0_write_r", isa_pkg::FN_ADDU, isa_pkg::ALU_ADD, 5'd0, 5'd1, 5'd1);
        add_r("r0_reads_zero", isa_pkg::FN_OR, isa_pkg::ALU_OR, 5'd16, 5'd0, 5'd1);
        add_r("r0_subu", isa_pkg::FN_SUBU, isa_pkg::ALU_SUB, 5'd17, 5'd15, 5'd0);
        for (int i = 0; i < 8; i++) begin
            add_i($sformatf("fill_%0d", i), isa_pkg::OP_ADDIU, isa_pkg::ALU_ADD,
                  5'd18, 5'd18, 16'(i + 1));
        end
    endtask

    function automatic isa_pkg::word_t ref_alu(input isa_pkg::alu_op_e op,
                                               input isa_pkg::word_t a,
                                               input isa_pkg::word_t b);
        case (op)
            isa_pkg::ALU_ADD: return a + b;
            isa_pkg::ALU_SUB: return a - b;
            isa_pkg::ALU_AND: return a & b;
            isa_pkg::ALU_OR:  return a | b;
            isa_pkg::ALU_XOR: return a ^ b;
            isa_pkg::ALU_NOR: return ~(a | b);
            isa_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            isa_pkg::ALU_LUI: return b;
            default:          return '0;
        endcase
    endfunction

    // Shadow registers walk the table in program order
    task automatic build_expected();
        isa_pkg::word_t shadow [32];
        isa_pkg::word_t b;
        record_t        rec;
        foreach (shadow[i]) shadow[i] = '0;
        foreach (prog[i]) begin
            b = prog[i].use_imm ? prog[i].imm : shadow[prog[i].rt];
            if (prog[i].rd != 5'd0) begin
                shadow[prog[i].rd] = ref_alu(prog[i].op, shadow[prog[i].rs], b);
                rec.name = prog[i].name;
                rec.pc   = core_pkg::RESET_PC + 32'(4 * i);
                rec.rd   = prog[i].rd;
                rec.data = shadow[prog[i].rd];
                expected.push_back(rec);
            end
        end
    endtask

    // Past the table the ROM returns an SLL to r0
    function automatic isa_pkg::inst_t rom_read(input isa_pkg::word_t adr);
        int idx;
        idx = int'((adr - core_pkg::RESET_PC) >> 2);
        if (idx < prog.size()) begin
            return prog[idx].inst;
        end
        return '0;
    endfunction

    always @(negedge clk) begin
        if (!rst_n_i) begin
            wb_ack_i <= 1'b0;
        end else if (wb_stb_o && !wb_ack_i) begin
            if (wait_left == 0) begin
                check_word("fetch_addr", next_adr, wb_adr_o);
                wb_dat_i <= rom_read(wb_adr_o);
                wb_ack_i <= 1'b1;
                next_adr = next_adr + 32'd4;
                ack_count++;
            end else begin
                wait_left--;
            end
        end else begin
            wb_ack_i <= 1'b0;
            rng = lcg_next(rng);
            wait_left = int'(rng[17:16]);
        end
    end

    // Trace monitor
    always @(negedge clk) begin
        record_t e;
        if (rst_n_i && wb_we_o) begin
            rec_count++;
            if (expected.size() == 0) begin
                $display("ERROR: unexpected trace record at pc %h", wb_pc_o);
                other_count++;
            end else begin
                e = expected.pop_front();
                check_word({e.name, " pc"}, e.pc, wb_pc_o);
                check_reg({e.name, " dest"}, e.rd, wb_waddr_o);
                check_word({e.name, " data"}, e.data, wb_wdata_o);
            end
        end
    end

    task automatic wait_records(input int target, input string what);
        int cycles;
        cycles = 0;
        while (rec_count < target && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (rec_count < target) begin
            $display("ERROR: timed out waiting for %s, saw %0d of %0d trace records",
                     what, rec_count, target);
            timeout_count++;
        end
    endtask

    initial begin
        int total;
        int rec_snap;
        int ack_snap;
        int assert_count;
        build_program();
        build_expected();
        total = expected.size();
        repeat (16) @(negedge clk);
        check_bit("reset_cyc", 1'b0, wb_cyc_o);
        check_bit("reset_stb", 1'b0, wb_stb_o);
        check_bit("reset_we", 1'b0, wb_we_o);
        check_word("reset_pc", core_pkg::RESET_PC, wb_adr_o);
        rst_n_i <= 1'b1;
        wait_records(6, "the records before the stall");

        @(negedge clk);
        stall_i = 1'b1;
        @(posedge clk);
        rec_snap = rec_count;
        ack_snap = ack_count;
        repeat (40) @(posedge clk);
        if (rec_count != rec_snap) begin
            $display("ERROR: %0d trace records appeared while stall was held",
                     rec_count - rec_snap);
            other_count++;
        end
        if (ack_count - ack_snap > core_pkg::QUEUE_DEPTH) begin
            $display("ERROR: %0d fetches completed during stall with a queue of %0d",
                     ack_count - ack_snap, core_pkg::QUEUE_DEPTH);
            other_count++;
        end
        @(negedge clk);
        check_bit("stall_fetch_idle", 1'b0, wb_cyc_o);
        stall_i = 1'b0;

        wait_records(total, "the records after the stall");
        repeat (20) @(posedge clk);
        if (expected.size() != 0) begin
            $display("ERROR: %0d expected trace records never appeared", expected.size());
            other_count++;
        end

        assert_count = DUT.u_fetch.u_props.fail_count;
        $display("Errors: %0d mismatches, %0d timeouts, %0d other, %0d assertion failures",
                 mismatch_count, timeout_count, other_count, assert_count);
        if (mismatch_count + timeout_count + other_count + assert_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- src.f
logic/isa_pkg.sv
logic/core_pkg.sv
logic/queue_if.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/inst_queue.sv
logic/exec_unit.sv
logic/mips_core.sv
sim/core_properties.sv
sim/mips_core_tb.sv
